/* common/lsu_pkg.sv */
package lsu_pkg;

    // Datapath sizes.
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 10;                    // Byte address at the top ports.
    localparam int WORD_ADDR_W = 8;                     // 256 words in the RAM.
    localparam int OFF_W       = ADDR_W - WORD_ADDR_W;  // Byte offset within a word.
    localparam int BE_W        = DATA_W / 8;

    // Flow control and queue sizes.
    localparam int QUEUE_DEPTH = 2;                     // Also the initial credit count.
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
    localparam int PEND_DEPTH  = QUEUE_DEPTH + 1;       // Queue entries plus the RAM stage.
    localparam int PPTR_W      = $clog2(PEND_DEPTH);
    localparam int CREDIT_W    = 2;

    localparam logic [PPTR_W-1:0]   PEND_LAST   = PPTR_W'(PEND_DEPTH - 1);
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(QUEUE_DEPTH);

    // Loads first, then stores, so a store is any op from LS_SB up.
    typedef enum logic [2:0] {
        LS_LB  = 3'd0,
        LS_LBU = 3'd1,
        LS_LH  = 3'd2,
        LS_LHU = 3'd3,
        LS_LW  = 3'd4,
        LS_SB  = 3'd5,
        LS_SH  = 3'd6,
        LS_SW  = 3'd7
    } ls_op_e;

    typedef enum logic {
        PORT_0 = 1'b0,
        PORT_1 = 1'b1
    } port_e;

endpackage

/* lsu/lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    input  lsu_pkg::ls_op_e                 req_op,
    input  logic [lsu_pkg::ADDR_W-1:0]      req_addr,
    input  logic [lsu_pkg::DATA_W-1:0]      req_wdata,
    output logic                            req_ready,
    output logic                            resp_valid,
    output logic [lsu_pkg::DATA_W-1:0]      resp_data,
    output logic                            cmd_valid,
    output logic                            cmd_we,
    output logic [lsu_pkg::BE_W-1:0]        cmd_be,
    output logic [lsu_pkg::WORD_ADDR_W-1:0] cmd_addr,
    output logic [lsu_pkg::DATA_W-1:0]      cmd_wdata,
    input  logic                            credit_return,
    input  logic                            rsp_valid,
    input  logic [lsu_pkg::DATA_W-1:0]      rsp_rdata
);

    logic [lsu_pkg::CREDIT_W-1:0] credits;
    logic                         accept;
    logic                         is_store;
    logic [lsu_pkg::OFF_W-1:0]    req_off;

    lsu_pkg::ls_op_e              pend_op  [lsu_pkg::PEND_DEPTH];
    logic [lsu_pkg::OFF_W-1:0]    pend_off [lsu_pkg::PEND_DEPTH];
    logic [lsu_pkg::PPTR_W-1:0]   pend_wr_ptr;
    logic [lsu_pkg::PPTR_W-1:0]   pend_rd_ptr;
    lsu_pkg::ls_op_e              head_op;
    logic [lsu_pkg::OFF_W-1:0]    head_off;
    logic [7:0]                   rsp_byte;
    logic [15:0]                  rsp_half;

    assign req_ready = (credits != '0);  // A credit is held.
    assign accept    = req_valid && req_ready;
    assign is_store  = req_op inside {lsu_pkg::LS_SB, lsu_pkg::LS_SH, lsu_pkg::LS_SW};
    assign req_off   = req_addr[lsu_pkg::OFF_W-1:0];

    assign cmd_valid = accept;
    assign cmd_we    = is_store;
    assign cmd_addr  = req_addr[lsu_pkg::ADDR_W-1:lsu_pkg::OFF_W];

    always_comb begin
        cmd_be    = '0;
        cmd_wdata = req_wdata;
        case (req_op)
            lsu_pkg::LS_SB: begin
                cmd_be    = {{(lsu_pkg::BE_W-1){1'b0}}, 1'b1} << req_off;
                cmd_wdata = {4{req_wdata[7:0]}};
            end
            lsu_pkg::LS_SH: begin
                cmd_be    = req_off[1] ? 4'b1100 : 4'b0011;  // Bit 0 is ignored.
                cmd_wdata = {2{req_wdata[15:0]}};
            end
            lsu_pkg::LS_SW: begin
                cmd_be    = '1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= lsu_pkg::CREDIT_INIT;
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    // Pending loads, popped in order as read data comes back.
    always_ff @(posedge clk) begin
        if (accept && !is_store) begin
            pend_op[pend_wr_ptr]  <= req_op;
            pend_off[pend_wr_ptr] <= req_off;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_wr_ptr <= '0;
            pend_rd_ptr <= '0;
        end else begin
            if (accept && !is_store) begin
                pend_wr_ptr <= (pend_wr_ptr == lsu_pkg::PEND_LAST) ? '0 : pend_wr_ptr + 1'b1;
            end
            if (rsp_valid) begin
                pend_rd_ptr <= (pend_rd_ptr == lsu_pkg::PEND_LAST) ? '0 : pend_rd_ptr + 1'b1;
            end
        end
    end

    assign head_op  = pend_op[pend_rd_ptr];
    assign head_off = pend_off[pend_rd_ptr];
    assign rsp_byte = rsp_rdata[{head_off, 3'b000} +: 8];
    assign rsp_half = head_off[1] ? rsp_rdata[31:16] : rsp_rdata[15:0];

    always_comb begin
        case (head_op)
            lsu_pkg::LS_LB:  resp_data = {{24{rsp_byte[7]}}, rsp_byte};
            lsu_pkg::LS_LBU: resp_data = {24'b0, rsp_byte};
            lsu_pkg::LS_LH:  resp_data = {{16{rsp_half[15]}}, rsp_half};
            lsu_pkg::LS_LHU: resp_data = {16'b0, rsp_half};
            default:         resp_data = rsp_rdata;
        endcase
    end

    assign resp_valid = rsp_valid;

endmodule

/* mem_subsys.f */
common/lsu_pkg.sv
lsu/lsu.sv
ram_arbiter/req_queue.sv
ram_arbiter/ram_arbiter.sv
src/data_ram.sv
src/mem_subsys.sv
testbench/mem_subsys_properties.sv
testbench/mem_subsys_tb.sv

/* ram_arbiter/ram_arbiter.sv */
`timescale 1ns/1ps

module ram_arbiter (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            p0_cmd_valid,
    input  logic                            p0_cmd_we,
    input  logic [lsu_pkg::BE_W-1:0]        p0_cmd_be,
    input  logic [lsu_pkg::WORD_ADDR_W-1:0] p0_cmd_addr,
    input  logic [lsu_pkg::DATA_W-1:0]      p0_cmd_wdata,
    output logic                            p0_credit_return,
    output logic                            p0_rsp_valid,
    output logic [lsu_pkg::DATA_W-1:0]      p0_rsp_rdata,
    input  logic                            p1_cmd_valid,
    input  logic                            p1_cmd_we,
    input  logic [lsu_pkg::BE_W-1:0]        p1_cmd_be,
    input  logic [lsu_pkg::WORD_ADDR_W-1:0] p1_cmd_addr,
    input  logic [lsu_pkg::DATA_W-1:0]      p1_cmd_wdata,
    output logic                            p1_credit_return,
    output logic                            p1_rsp_valid,
    output logic [lsu_pkg::DATA_W-1:0]      p1_rsp_rdata,
    output logic                            ram_en,
    output logic                            ram_we,
    output logic [lsu_pkg::BE_W-1:0]        ram_be,
    output logic [lsu_pkg::WORD_ADDR_W-1:0] ram_addr,
    output logic [lsu_pkg::DATA_W-1:0]      ram_wdata,
    output lsu_pkg::port_e                  ram_tag,
    input  logic                            rd_valid,
    input  lsu_pkg::port_e                  rd_tag,
    input  logic [lsu_pkg::DATA_W-1:0]      rd_data
);

    logic                            p0_empty, p0_head_we, p0_pop;
    logic [lsu_pkg::BE_W-1:0]        p0_head_be;
    logic [lsu_pkg::WORD_ADDR_W-1:0] p0_head_addr;
    logic [lsu_pkg::DATA_W-1:0]      p0_head_wdata;
    logic                            p1_empty, p1_head_we, p1_pop;
    logic [lsu_pkg::BE_W-1:0]        p1_head_be;
    logic [lsu_pkg::WORD_ADDR_W-1:0] p1_head_addr;
    logic [lsu_pkg::DATA_W-1:0]      p1_head_wdata;
    logic                            grant_valid;
    lsu_pkg::port_e                  grant_port;
    lsu_pkg::port_e                  last_grant;

    req_queue p0_queue_inst (
        .clk(clk), .rst_n(rst_n),
        .push(p0_cmd_valid), .push_we(p0_cmd_we), .push_be(p0_cmd_be),
        .push_addr(p0_cmd_addr), .push_wdata(p0_cmd_wdata), .pop(p0_pop),
        .empty(p0_empty), .head_we(p0_head_we), .head_be(p0_head_be),
        .head_addr(p0_head_addr), .head_wdata(p0_head_wdata)
    );

    req_queue p1_queue_inst (
        .clk(clk), .rst_n(rst_n),
        .push(p1_cmd_valid), .push_we(p1_cmd_we), .push_be(p1_cmd_be),
        .push_addr(p1_cmd_addr), .push_wdata(p1_cmd_wdata), .pop(p1_pop),
        .empty(p1_empty), .head_we(p1_head_we), .head_be(p1_head_be),
        .head_addr(p1_head_addr), .head_wdata(p1_head_wdata)
    );

    // Round robin. On a tie the port not granted last wins.
    always_comb begin
        grant_valid = !p0_empty || !p1_empty;
        if (!p0_empty && !p1_empty) begin
            grant_port = (last_grant == lsu_pkg::PORT_0) ? lsu_pkg::PORT_1 : lsu_pkg::PORT_0;
        end else if (!p1_empty) begin
            grant_port = lsu_pkg::PORT_1;
        end else begin
            grant_port = lsu_pkg::PORT_0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_grant <= lsu_pkg::PORT_1;  // Port 0 goes first.
        end else if (grant_valid) begin
            last_grant <= grant_port;
        end
    end

    assign p0_pop           = grant_valid && (grant_port == lsu_pkg::PORT_0);
    assign p1_pop           = grant_valid && (grant_port == lsu_pkg::PORT_1);
    assign p0_credit_return = p0_pop;  // The freed entry is a credit.
    assign p1_credit_return = p1_pop;

    assign ram_en    = grant_valid;
    assign ram_tag   = grant_port;
    assign ram_we    = p1_pop ? p1_head_we    : p0_head_we;
    assign ram_be    = p1_pop ? p1_head_be    : p0_head_be;
    assign ram_addr  = p1_pop ? p1_head_addr  : p0_head_addr;
    assign ram_wdata = p1_pop ? p1_head_wdata : p0_head_wdata;

    assign p0_rsp_valid = rd_valid && (rd_tag == lsu_pkg::PORT_0);
    assign p1_rsp_valid = rd_valid && (rd_tag == lsu_pkg::PORT_1);
    assign p0_rsp_rdata = rd_data;
    assign p1_rsp_rdata = rd_data;

endmodule

/* ram_arbiter/req_queue.sv */
`timescale 1ns/1ps

module req_queue (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            push,
    input  logic                            push_we,
    input  logic [lsu_pkg::BE_W-1:0]        push_be,
    input  logic [lsu_pkg::WORD_ADDR_W-1:0] push_addr,
    input  logic [lsu_pkg::DATA_W-1:0]      push_wdata,
    input  logic                            pop,
    output logic                            empty,
    output logic                            head_we,
    output logic [lsu_pkg::BE_W-1:0]        head_be,
    output logic [lsu_pkg::WORD_ADDR_W-1:0] head_addr,
    output logic [lsu_pkg::DATA_W-1:0]      head_wdata
);

    logic                            ent_we    [lsu_pkg::QUEUE_DEPTH];
    logic [lsu_pkg::BE_W-1:0]        ent_be    [lsu_pkg::QUEUE_DEPTH];
    logic [lsu_pkg::WORD_ADDR_W-1:0] ent_addr  [lsu_pkg::QUEUE_DEPTH];
    logic [lsu_pkg::DATA_W-1:0]      ent_wdata [lsu_pkg::QUEUE_DEPTH];
    logic [lsu_pkg::QPTR_W-1:0]      wr_ptr;
    logic [lsu_pkg::QPTR_W-1:0]      rd_ptr;
    logic [lsu_pkg::QCNT_W-1:0]      count;

    always_ff @(posedge clk) begin
        if (push) begin
            ent_we[wr_ptr]    <= push_we;
            ent_be[wr_ptr]    <= push_be;
            ent_addr[wr_ptr]  <= push_addr;
            ent_wdata[wr_ptr] <= push_wdata;
        end
    end

    // Depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign empty      = (count == '0);
    assign head_we    = ent_we[rd_ptr];
    assign head_be    = ent_be[rd_ptr];
    assign head_addr  = ent_addr[rd_ptr];
    assign head_wdata = ent_wdata[rd_ptr];

endmodule

/* src/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            we,
    input  logic [lsu_pkg::BE_W-1:0]        be,
    input  logic [lsu_pkg::WORD_ADDR_W-1:0] addr,
    input  logic [lsu_pkg::DATA_W-1:0]      wdata,
    input  lsu_pkg::port_e                  tag,
    output logic                            rd_valid,
    output lsu_pkg::port_e                  rd_tag,
    output logic [lsu_pkg::DATA_W-1:0]      rd_data
);

    logic [lsu_pkg::DATA_W-1:0] mem [2**lsu_pkg::WORD_ADDR_W];

    // Byte lanes are written only where the enable is set.
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int i = 0; i < lsu_pkg::BE_W; i++) begin
                if (be[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && !we) begin
            rd_data <= mem[addr];
            rd_tag  <= tag;  // Names the port that gets the data.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= en && !we;
        end
    end

endmodule

/* src/mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       p0_req_valid,
    input  lsu_pkg::ls_op_e            p0_req_op,
    input  logic [lsu_pkg::ADDR_W-1:0] p0_req_addr,
    input  logic [lsu_pkg::DATA_W-1:0] p0_req_wdata,
    output logic                       p0_req_ready,
    output logic                       p0_resp_valid,
    output logic [lsu_pkg::DATA_W-1:0] p0_resp_data,
    input  logic                       p1_req_valid,
    input  lsu_pkg::ls_op_e            p1_req_op,
    input  logic [lsu_pkg::ADDR_W-1:0] p1_req_addr,
    input  logic [lsu_pkg::DATA_W-1:0] p1_req_wdata,
    output logic                       p1_req_ready,
    output logic                       p1_resp_valid,
    output logic [lsu_pkg::DATA_W-1:0] p1_resp_data
);

    logic                            p0_cmd_valid, p0_cmd_we, p0_credit_return, p0_rsp_valid;
    logic [lsu_pkg::BE_W-1:0]        p0_cmd_be;
    logic [lsu_pkg::WORD_ADDR_W-1:0] p0_cmd_addr;
    logic [lsu_pkg::DATA_W-1:0]      p0_cmd_wdata, p0_rsp_rdata;
    logic                            p1_cmd_valid, p1_cmd_we, p1_credit_return, p1_rsp_valid;
    logic [lsu_pkg::BE_W-1:0]        p1_cmd_be;
    logic [lsu_pkg::WORD_ADDR_W-1:0] p1_cmd_addr;
    logic [lsu_pkg::DATA_W-1:0]      p1_cmd_wdata, p1_rsp_rdata;

    logic                            ram_en, ram_we, rd_valid;
    logic [lsu_pkg::BE_W-1:0]        ram_be;
    logic [lsu_pkg::WORD_ADDR_W-1:0] ram_addr;
    logic [lsu_pkg::DATA_W-1:0]      ram_wdata, rd_data;
    lsu_pkg::port_e                  ram_tag, rd_tag;

    lsu p0_lsu_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(p0_req_valid), .req_op(p0_req_op), .req_addr(p0_req_addr),
        .req_wdata(p0_req_wdata), .req_ready(p0_req_ready),
        .resp_valid(p0_resp_valid), .resp_data(p0_resp_data),
        .cmd_valid(p0_cmd_valid), .cmd_we(p0_cmd_we), .cmd_be(p0_cmd_be),
        .cmd_addr(p0_cmd_addr), .cmd_wdata(p0_cmd_wdata),
        .credit_return(p0_credit_return), .rsp_valid(p0_rsp_valid), .rsp_rdata(p0_rsp_rdata)
    );

    lsu p1_lsu_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(p1_req_valid), .req_op(p1_req_op), .req_addr(p1_req_addr),
        .req_wdata(p1_req_wdata), .req_ready(p1_req_ready),
        .resp_valid(p1_resp_valid), .resp_data(p1_resp_data),
        .cmd_valid(p1_cmd_valid), .cmd_we(p1_cmd_we), .cmd_be(p1_cmd_be),
        .cmd_addr(p1_cmd_addr), .cmd_wdata(p1_cmd_wdata),
        .credit_return(p1_credit_return), .rsp_valid(p1_rsp_valid), .rsp_rdata(p1_rsp_rdata)
    );

    ram_arbiter ram_arbiter_inst (
        .clk(clk), .rst_n(rst_n),
        .p0_cmd_valid(p0_cmd_valid), .p0_cmd_we(p0_cmd_we), .p0_cmd_be(p0_cmd_be),
        .p0_cmd_addr(p0_cmd_addr), .p0_cmd_wdata(p0_cmd_wdata),
        .p0_credit_return(p0_credit_return), .p0_rsp_valid(p0_rsp_valid),
        .p0_rsp_rdata(p0_rsp_rdata),
        .p1_cmd_valid(p1_cmd_valid), .p1_cmd_we(p1_cmd_we), .p1_cmd_be(p1_cmd_be),
        .p1_cmd_addr(p1_cmd_addr), .p1_cmd_wdata(p1_cmd_wdata),
        .p1_credit_return(p1_credit_return), .p1_rsp_valid(p1_rsp_valid),
        .p1_rsp_rdata(p1_rsp_rdata),
        .ram_en(ram_en), .ram_we(ram_we), .ram_be(ram_be), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_tag(ram_tag),
        .rd_valid(rd_valid), .rd_tag(rd_tag), .rd_data(rd_data)
    );

    data_ram data_ram_inst (
        .clk(clk), .rst_n(rst_n),
        .en(ram_en), .we(ram_we), .be(ram_be), .addr(ram_addr),
        .wdata(ram_wdata), .tag(ram_tag),
        .rd_valid(rd_valid), .rd_tag(rd_tag), .rd_data(rd_data)
    );

endmodule

/* testbench/mem_subsys_properties.sv */
`timescale 1ns/1ps

module mem_subsys_properties (
    input logic clk,
    input logic rst_n,
    input logic p0_push,
    input logic p0_pop,
    input logic p0_empty,
    input logic p0_credit_return,
    input logic p1_push,
    input logic p1_pop,
    input logic p1_empty,
    input logic p1_credit_return,
    input logic ram_en
);

    logic [lsu_pkg::QCNT_W-1:0] p0_fill;
    logic [lsu_pkg::QCNT_W-1:0] p1_fill;

    // Shadow fill counts that follow push and pop on each queue.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p0_fill <= '0;
            p1_fill <= '0;
        end else begin
            case ({p0_push, p0_pop})
                2'b10:   p0_fill <= p0_fill + 1'b1;
                2'b01:   p0_fill <= p0_fill - 1'b1;
                default: ;
            endcase
            case ({p1_push, p1_pop})
                2'b10:   p1_fill <= p1_fill + 1'b1;
                2'b01:   p1_fill <= p1_fill - 1'b1;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) p0_push |-> p0_fill < lsu_pkg::QUEUE_DEPTH)
        else $error("Port 0 queue pushed while full");
    assert property (@(posedge clk) disable iff (!rst_n) p1_push |-> p1_fill < lsu_pkg::QUEUE_DEPTH)
        else $error("Port 1 queue pushed while full");
    assert property (@(posedge clk) disable iff (!rst_n) p0_pop |-> p0_fill != '0)
        else $error("Port 0 queue popped while empty");
    assert property (@(posedge clk) disable iff (!rst_n) p1_pop |-> p1_fill != '0)
        else $error("Port 1 queue popped while empty");
    assert property (@(posedge clk) disable iff (!rst_n) p0_credit_return |-> p0_fill != '0)
        else $error("Port 0 credit returned with its queue empty");
    assert property (@(posedge clk) disable iff (!rst_n) p1_credit_return |-> p1_fill != '0)
        else $error("Port 1 credit returned with its queue empty");
    assert property (@(posedge clk) disable iff (!rst_n)
                     ram_en |-> (p0_fill != '0 || p1_fill != '0))
        else $error("RAM enabled while both queues are empty");
    assert property (@(posedge clk) disable iff (!rst_n) p0_empty == (p0_fill == '0))
        else $error("Port 0 empty flag disagrees with its fill count");
    assert property (@(posedge clk) disable iff (!rst_n) p1_empty == (p1_fill == '0))
        else $error("Port 1 empty flag disagrees with its fill count");

endmodule

/* testbench/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;
    localparam int REGION_BYTES = 512;
    localparam int REGION_WORDS = REGION_BYTES / 4;
    localparam int FMT_ROUNDS   = 24;   // One SB or SH plus one LW each.
    localparam int EXT_ROUNDS   = 3;    // One SW plus 16 loads each.
    localparam int MIX_OPS      = 40;
    localparam int BURST_OPS    = 24;
    localparam int TXN_PER_PORT = 2 * REGION_WORDS + 2 * FMT_ROUNDS + 17 * EXT_ROUNDS
                                  + MIX_OPS + BURST_OPS;
    localparam int CYCLE_LIMIT  = 2 * TXN_PER_PORT * 20;

    logic                       clk;
    logic                       rst_n;
    logic                       p0_req_valid, p1_req_valid;
    lsu_pkg::ls_op_e            p0_req_op, p1_req_op;
    logic [lsu_pkg::ADDR_W-1:0] p0_req_addr, p1_req_addr;
    logic [lsu_pkg::DATA_W-1:0] p0_req_wdata, p1_req_wdata;
    logic                       p0_req_ready, p1_req_ready;
    logic                       p0_resp_valid, p1_resp_valid;
    logic [lsu_pkg::DATA_W-1:0] p0_resp_data, p1_resp_data;

    logic [7:0]  model_mem [2**lsu_pkg::ADDR_W];  // Byte view of the whole RAM.
    logic [31:0] exp_q0 [$];
    logic [31:0] exp_q1 [$];
    int          loads_issued [2];
    int          responses [2];
    int          value_errors = 0;
    int          other_errors = 0;
    int          checks = 0;
    int          stalls = 0;
    int          cycles = 0;

    mem_subsys mem_subsys_inst (
        .clk(clk), .rst_n(rst_n),
        .p0_req_valid(p0_req_valid), .p0_req_op(p0_req_op), .p0_req_addr(p0_req_addr),
        .p0_req_wdata(p0_req_wdata), .p0_req_ready(p0_req_ready),
        .p0_resp_valid(p0_resp_valid), .p0_resp_data(p0_resp_data),
        .p1_req_valid(p1_req_valid), .p1_req_op(p1_req_op), .p1_req_addr(p1_req_addr),
        .p1_req_wdata(p1_req_wdata), .p1_req_ready(p1_req_ready),
        .p1_resp_valid(p1_resp_valid), .p1_resp_data(p1_resp_data)
    );

    bind ram_arbiter mem_subsys_properties mem_subsys_properties_inst (
        .clk(clk), .rst_n(rst_n),
        .p0_push(p0_cmd_valid), .p0_pop(p0_pop), .p0_empty(p0_empty),
        .p0_credit_return(p0_credit_return),
        .p1_push(p1_cmd_valid), .p1_pop(p1_pop), .p1_empty(p1_empty),
        .p1_credit_return(p1_credit_return),
        .ram_en(ram_en)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    // Little endian: byte lane i of a word sits at byte address word + i.
    function automatic logic [31:0] expected_load(lsu_pkg::ls_op_e op, int addr);
        logic [7:0]  b;
        logic [15:0] h;
        int          ha;
        int          wa;
        ha = addr & ~1;
        wa = addr & ~3;
        b  = model_mem[addr];
        h  = {model_mem[ha + 1], model_mem[ha]};
        case (op)
            lsu_pkg::LS_LB:  return {{24{b[7]}}, b};
            lsu_pkg::LS_LBU: return {24'h0, b};
            lsu_pkg::LS_LH:  return {{16{h[15]}}, h};
            lsu_pkg::LS_LHU: return {16'h0, h};
            default: begin
                return {model_mem[wa + 3], model_mem[wa + 2], model_mem[wa + 1], model_mem[wa]};
            end
        endcase
    endfunction

    function automatic void store_model(lsu_pkg::ls_op_e op, int addr, logic [31:0] data);
        int ha;
        int wa;
        ha = addr & ~1;
        wa = addr & ~3;
        if (op == lsu_pkg::LS_SB) begin
            model_mem[addr] = data[7:0];
        end else if (op == lsu_pkg::LS_SH) begin
            model_mem[ha]     = data[7:0];
            model_mem[ha + 1] = data[15:8];
        end else begin
            for (int i = 0; i < 4; i++) begin
                model_mem[wa + i] = data[i*8 +: 8];
            end
        end
    endfunction

    function automatic int random_word(int port);
        return port * REGION_BYTES + 4 * $urandom_range(0, REGION_WORDS - 1);
    endfunction

    // Holds the request until req_ready is seen; it is taken at the next rising edge.
    task automatic issue(int port, lsu_pkg::ls_op_e op, int addr, logic [31:0] data);
        logic ready;
        @(negedge clk);
        if (port == 0) begin
            p0_req_valid = 1'b1;
            p0_req_op    = op;
            p0_req_addr  = addr[lsu_pkg::ADDR_W-1:0];
            p0_req_wdata = data;
        end else begin
            p1_req_valid = 1'b1;
            p1_req_op    = op;
            p1_req_addr  = addr[lsu_pkg::ADDR_W-1:0];
            p1_req_wdata = data;
        end
        ready = (port == 0) ? p0_req_ready : p1_req_ready;
        while (!ready) begin
            stalls++;
            @(negedge clk);
            ready = (port == 0) ? p0_req_ready : p1_req_ready;
        end
        if (op inside {lsu_pkg::LS_SB, lsu_pkg::LS_SH, lsu_pkg::LS_SW}) begin
            store_model(op, addr, data);
        end else begin
            loads_issued[port]++;
            if (port == 0) begin
                exp_q0.push_back(expected_load(op, addr));
            end else begin
                exp_q1.push_back(expected_load(op, addr));
            end
        end
    endtask

    task automatic go_idle(int port);
        @(negedge clk);
        if (port == 0) begin
            p0_req_valid = 1'b0;
        end else begin
            p1_req_valid = 1'b0;
        end
    endtask

    task automatic drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic init_region(int port);
        for (int w = 0; w < REGION_WORDS; w++) begin
            issue(port, lsu_pkg::LS_SW, port * REGION_BYTES + 4 * w, $urandom());
        end
        for (int w = 0; w < REGION_WORDS; w++) begin
            issue(port, lsu_pkg::LS_LW, port * REGION_BYTES + 4 * w, 32'h0);
        end
        go_idle(port);
    endtask

    task automatic store_format(int port);
        lsu_pkg::ls_op_e op;
        int              addr;
        for (int i = 0; i < FMT_ROUNDS; i++) begin
            addr = random_word(port) + (i % 4);
            op   = ((i / 4) % 2 == 0) ? lsu_pkg::LS_SB : lsu_pkg::LS_SH;
            issue(port, op, addr, $urandom());
            issue(port, lsu_pkg::LS_LW, addr, 32'h0);
        end
        go_idle(port);
    endtask

    task automatic load_extend(int port);
        logic [31:0] data;
        int          base;
        for (int i = 0; i < EXT_ROUNDS; i++) begin
            base = random_word(port);
            data = $urandom();
            data = (i % 2 == 0) ? (data | 32'h8080_8080) : (data & 32'h7f7f_7f7f);
            issue(port, lsu_pkg::LS_SW, base, data);
            for (int off = 0; off < 4; off++) begin
                issue(port, lsu_pkg::LS_LB, base + off, 32'h0);
                issue(port, lsu_pkg::LS_LBU, base + off, 32'h0);
                issue(port, lsu_pkg::LS_LH, base + off, 32'h0);
                issue(port, lsu_pkg::LS_LHU, base + off, 32'h0);
            end
        end
        go_idle(port);
    endtask

    task automatic random_traffic(int port, int count, bit loads_only);
        lsu_pkg::ls_op_e op;
        for (int i = 0; i < count; i++) begin
            if (loads_only) begin
                op = lsu_pkg::ls_op_e'($urandom_range(0, 4));
            end else begin
                op = lsu_pkg::ls_op_e'($urandom_range(0, 7));
            end
            issue(port, op, random_word(port) + $urandom_range(0, 3), $urandom());
        end
        go_idle(port);
    endtask

    task automatic check_response(int port, logic [31:0] actual);
        logic [31:0] expected;
        responses[port]++;
        if ((port == 0 && exp_q0.size() == 0) || (port == 1 && exp_q1.size() == 0)) begin
            other_errors++;
            $display("Port %0d gave a response at %0t with no load outstanding", port, $time);
        end else begin
            if (port == 0) begin
                expected = exp_q0.pop_front();
            end else begin
                expected = exp_q1.pop_front();
            end
            checks++;
            if (actual !== expected) begin
                value_errors++;
                $display("Fail at %0t: p%0d_resp_data expected %h, got %h",
                         $time, port, expected, actual);
            end
        end
    endtask

    task automatic report_counts();
        $display("Checks %0d, value errors %0d, other errors %0d, stalled cycles %0d",
                 checks, value_errors, other_errors, stalls);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (p0_resp_valid) check_response(0, p0_resp_data);
            if (p1_resp_valid) check_response(1, p1_resp_data);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            other_errors++;
            $display("Timeout after %0d cycles, loads still waiting on port 0: %0d, port 1: %0d",
                     cycles, exp_q0.size(), exp_q1.size());
            report_counts();
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int stalls_before;
        void'($urandom(32'hb4dc_a3ca));
        rst_n        = 1'b0;
        p0_req_valid = 1'b0;
        p0_req_op    = lsu_pkg::LS_LW;
        p0_req_addr  = '0;
        p0_req_wdata = '0;
        p1_req_valid = 1'b0;
        p1_req_op    = lsu_pkg::LS_LW;
        p1_req_addr  = '0;
        p1_req_wdata = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        if (!p0_req_ready || !p1_req_ready || p0_resp_valid || p1_resp_valid) begin
            other_errors++;
            $display("Outputs are not in their idle state after reset");
        end

        fork
            init_region(0);
            init_region(1);
        join
        drain();
        fork
            store_format(0);
            store_format(1);
        join
        drain();
        fork
            load_extend(0);
            load_extend(1);
        join
        drain();
        fork
            random_traffic(0, MIX_OPS, 1'b0);
            random_traffic(1, MIX_OPS, 1'b0);
        join
        drain();
        stalls_before = stalls;
        fork
            random_traffic(0, BURST_OPS, 1'b1);
            random_traffic(1, BURST_OPS, 1'b1);
        join
        drain();
        if (stalls == stalls_before) begin
            other_errors++;
            $display("req_ready never dropped during the burst test");
        end

        repeat (4) @(negedge clk);  // Catch any late extra response.
        for (int p = 0; p < 2; p++) begin
            if (responses[p] != loads_issued[p]) begin
                value_errors++;
                $display("Fail at %0t: p%0d_resp_valid count expected %0d, got %0d",
                         $time, p, loads_issued[p], responses[p]);
            end
        end
        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
